//--- logic/spi_regs_pkg.sv
// spi register bank definitions
// register map, field types, reset values and the nibble update rule

package spi_regs_pkg;

  // host frame is one address byte then one data byte
  localparam int frame_bits_c = 16;

  typedef logic [7:0] addr_t;
  typedef logic [7:0] data_t;
  typedef logic [3:0] ctl_nibble_t;
  typedef logic [7:0] mux_t;

  //////////////////////////////////////////////////////////////////////
  // register map

  // command addresses, no storage behind them
  localparam addr_t reg_powerup_c    = 8'd6;
  localparam addr_t reg_soft_reset_c = 8'd11;

  // storage registers
  localparam addr_t reg_led_c        = 8'd7;
  localparam addr_t reg_spi_mux_c    = 8'd8;
  localparam addr_t reg_4094_c       = 8'd9;
  localparam addr_t reg_dac_c        = 8'd10;
  localparam addr_t reg_adc_c        = 8'd14;

  // reset values
  localparam ctl_nibble_t led_rst_c      = 4'h0;
  localparam ctl_nibble_t gpo_4094_rst_c = 4'h0;
  // dac control lines idle high
  localparam ctl_nibble_t dac_rst_c      = 4'hf;
  localparam ctl_nibble_t adc_rst_c      = 4'h0;
  localparam mux_t        spi_mux_rst_c  = 8'h00;

  //////////////////////////////////////////////////////////////////////
  // nibble update
  // set in low data nibble, clear in high nibble, both means toggle

  function automatic ctl_nibble_t nibble_update(
    input ctl_nibble_t old_val,
    input ctl_nibble_t set_bits,
    input ctl_nibble_t clr_bits
  );
    ctl_nibble_t both;
    ctl_nibble_t result;
    both   = set_bits & clr_bits;
    // toggle first, then plain set and clear on the other bits
    result = old_val ^ both;
    result = result | (set_bits & ~both);
    result = result & ~(clr_bits & ~both);
    return result;
  endfunction

endpackage

//--- logic/spi_bit_if.sv
`timescale 1ns/10ps
// bit level link between the spi pin sampler and the frame controller
// sampled pin events one way, read byte load requests the other

interface spi_bit_if
  import spi_regs_pkg::*;
();

  // level, synced cs_n low
  logic  cs_active;
  // single clk pulses
  logic  cs_fall;
  logic  cs_rise;
  logic  bit_strobe;
  // mosi, valid with bit_strobe
  logic  bit_val;

  // byte to shift out msb first on sdo
  logic  load;
  data_t load_byte;

  modport sampler (
    output cs_active, cs_fall, cs_rise, bit_strobe, bit_val,
    input  load, load_byte
  );

  modport ctrl (
    input  cs_active, cs_fall, cs_rise, bit_strobe, bit_val,
    output load, load_byte
  );

endinterface

//--- logic/reg_frame_if.sv
`timescale 1ns/10ps
// four-phase register transaction between frame controller and register file
// req up, ack up, req down, ack down

interface reg_frame_if
  import spi_regs_pkg::*;
();

  // controller side
  logic  req;
  logic  write_en;
  addr_t addr;
  data_t wdata;

  // register file side
  // rdata valid while ack high
  logic  ack;
  data_t rdata;

  modport ctrl (
    output req, write_en, addr, wdata,
    input  ack, rdata
  );

  modport regs (
    input  req, write_en, addr, wdata,
    output ack, rdata
  );

endinterface

//--- logic/spi_sampler.sv
`timescale 1ns/10ps
// spi pin front end
// syncs host pins into clk, detects cs and sclk edges
// and shifts the read byte out on sdo

module spi_sampler
  import spi_regs_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       sdo,
  spi_bit_if.sampler bits
);

  logic [1:0] sclk_sync;
  logic [1:0] cs_n_sync;
  logic [1:0] mosi_sync;
  logic       sclk_prev;
  logic       cs_n_prev;
  logic       cs_active;
  logic       sclk_fall;
  data_t      shreg;
  data_t      shreg_src;

  //////////////////////////////////////////////////////////////////////
  // synchronizers and edge history

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_sync <= 2'b00;
      // cs idles deasserted
      cs_n_sync <= 2'b11;
      mosi_sync <= 2'b00;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_n_sync <= {cs_n_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_prev <= sclk_sync[1];
      cs_n_prev <= cs_n_sync[1];
    end
  end

  assign cs_active       = !cs_n_sync[1];
  assign bits.cs_active  = cs_active;
  // frame start, cs_n high to low
  assign bits.cs_fall    = cs_n_prev && !cs_n_sync[1];
  // frame end
  assign bits.cs_rise    = !cs_n_prev && cs_n_sync[1];
  // mode 0, host data is stable around the rising edge
  assign bits.bit_strobe = sclk_sync[1] && !sclk_prev;
  assign bits.bit_val    = mosi_sync[1];
  assign sclk_fall       = !sclk_sync[1] && sclk_prev;

  //////////////////////////////////////////////////////////////////////
  // output shifter

  // a load landing on a falling edge still gets its msb out
  assign shreg_src = bits.load ? bits.load_byte : shreg;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      shreg <= '0;
      sdo   <= 1'b0;
    end
    else if (!cs_active)
    begin
      // idle between frames
      shreg <= '0;
      sdo   <= 1'b0;
    end
    else if (sclk_fall)
    begin
      // next bit out, msb first, zero fill
      sdo   <= shreg_src[$bits(data_t)-1];
      shreg <= shreg_src << 1;
    end
    else
    begin
      shreg <= shreg_src;
    end
  end

endmodule

//--- logic/frame_control.sv
`timescale 1ns/10ps
// spi frame controller
// counts bits, assembles address and data, runs the read after the
// address byte and the commit after cs goes high

module frame_control
  import spi_regs_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  spi_bit_if.ctrl   bits,
  reg_frame_if.ctrl frame
);

  // counter saturates one above a full frame
  localparam int cnt_w_c     = $clog2(frame_bits_c + 2);
  localparam int addr_bits_c = $bits(addr_t);
  localparam int data_bits_c = $bits(data_t);

  typedef enum logic [2:0] {
    st_idle,
    st_read_req,
    st_read_wait,
    st_shift,
    st_commit_req,
    st_commit_wait
  } state_t;

  state_t                  state;
  logic [cnt_w_c-1:0]      bit_cnt;
  logic [frame_bits_c-1:0] shift_q;
  logic                    byte_done;
  logic                    read_start;
  logic                    read_done;
  logic                    frame_end;
  logic                    full_frame;

  //////////////////////////////////////////////////////////////////////
  // bit counting

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (bits.cs_fall)
      bit_cnt <= '0;
    else if (bits.bit_strobe && (bit_cnt <= cnt_w_c'(frame_bits_c)))
      bit_cnt <= bit_cnt + 1'b1;
  end

  // 8th strobe of the frame
  assign byte_done  = bits.bit_strobe && (bit_cnt == cnt_w_c'(addr_bits_c - 1));
  assign full_frame = (bit_cnt == cnt_w_c'(frame_bits_c));
  assign read_start = (state == st_idle) && byte_done;
  assign read_done  = (state == st_read_req) && frame.req && frame.ack;
  // short frames end in idle, normal ones in shift
  assign frame_end  = ((state == st_idle) && bits.cs_rise) ||
                      ((state == st_shift) && !bits.cs_active);

  //////////////////////////////////////////////////////////////////////
  // main fsm with handshake tracking

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state          <= st_idle;
      frame.req      <= 1'b0;
      frame.write_en <= 1'b0;
      bits.load      <= 1'b0;
    end
    else
    begin
      bits.load <= 1'b0;
      case (state)
        st_idle, st_shift:
        begin
          if (read_start)
          begin
            state          <= st_read_req;
            // only raise once the last ack is gone
            frame.req      <= !frame.ack;
            frame.write_en <= 1'b0;
          end
          else if (frame_end)
          begin
            state          <= st_commit_req;
            frame.req      <= !frame.ack;
            frame.write_en <= full_frame;
          end
        end
        st_read_req:
        begin
          if (read_done)
          begin
            frame.req <= 1'b0;
            bits.load <= 1'b1;
            state     <= st_read_wait;
          end
          else if (!frame.ack)
            frame.req <= 1'b1;
        end
        // wait for ack to drop
        st_read_wait:
        begin
          if (!frame.ack)
            state <= st_shift;
        end
        st_commit_req:
        begin
          if (frame.req && frame.ack)
          begin
            frame.req <= 1'b0;
            state     <= st_commit_wait;
          end
          else if (!frame.ack)
            frame.req <= 1'b1;
        end
        st_commit_wait:
        begin
          if (!frame.ack)
          begin
            frame.write_en <= 1'b0;
            state          <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // payload shift in and transaction fields

  always_ff @(posedge clk)
  begin
    if (bits.cs_fall)
      shift_q <= '0;
    else if (bits.bit_strobe)
      shift_q <= {shift_q[frame_bits_c-2:0], bits.bit_val};

    // address byte completes with this strobe
    if (read_start)
      frame.addr <= {shift_q[addr_bits_c-2:0], bits.bit_val};
    else if (frame_end)
    begin
      frame.addr  <= shift_q[frame_bits_c-1 -: addr_bits_c];
      frame.wdata <= shift_q[data_bits_c-1:0];
    end

    // previous value goes back to the host
    if (read_done)
      bits.load_byte <= frame.rdata;
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps
// control register file
// nibble set/clear/toggle, one-hot mux from index, soft reset and powerup
// answers each request one clk after req rises

module reg_file
  import spi_regs_pkg::*;
#(
  parameter int periph_count = 8
) (
  input  logic                    clk,
  input  logic                    arst_n,
  reg_frame_if.regs               frame,
  output ctl_nibble_t             led,
  output ctl_nibble_t             gpo_4094,
  output ctl_nibble_t             dac_ctl,
  output ctl_nibble_t             adc_ctl,
  output logic [periph_count-1:0] spi_mux
);

  typedef logic [periph_count-1:0] periph_vec_t;

  logic        req_rise;
  logic        commit;
  ctl_nibble_t set_bits;
  ctl_nibble_t clr_bits;
  logic [3:0]  mux_index;
  periph_vec_t mux_next;
  data_t       read_val;

  // first cycle of a request
  assign req_rise  = frame.req && !frame.ack;
  assign commit    = req_rise && frame.write_en;
  assign set_bits  = frame.wdata[3:0];
  assign clr_bits  = frame.wdata[7:4];
  assign mux_index = frame.wdata[3:0];
  // index 0 deselects all, index n picks peripheral n-1
  assign mux_next  = (mux_index == 4'd0) ? '0 : (periph_vec_t'(1) << (mux_index - 4'd1));

  //////////////////////////////////////////////////////////////////////
  // read side

  always_comb
  begin
    case (frame.addr)
      reg_led_c:     read_val = data_t'(led);
      reg_spi_mux_c: read_val = data_t'(spi_mux);
      reg_4094_c:    read_val = data_t'(gpo_4094);
      reg_dac_c:     read_val = data_t'(dac_ctl);
      reg_adc_c:     read_val = data_t'(adc_ctl);
      // commands and holes read zero
      default:       read_val = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      frame.ack <= 1'b0;
    else
      frame.ack <= frame.req;
  end

  always_ff @(posedge clk)
  begin
    if (req_rise)
      frame.rdata <= read_val;
  end

  //////////////////////////////////////////////////////////////////////
  // write side

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led      <= led_rst_c;
      gpo_4094 <= gpo_4094_rst_c;
      dac_ctl  <= dac_rst_c;
      adc_ctl  <= adc_rst_c;
      spi_mux  <= periph_vec_t'(spi_mux_rst_c);
    end
    else if (commit)
    begin
      case (frame.addr)
        reg_led_c:     led      <= nibble_update(led, set_bits, clr_bits);
        reg_4094_c:    gpo_4094 <= nibble_update(gpo_4094, set_bits, clr_bits);
        reg_dac_c:     dac_ctl  <= nibble_update(dac_ctl, set_bits, clr_bits);
        reg_adc_c:     adc_ctl  <= nibble_update(adc_ctl, set_bits, clr_bits);
        reg_spi_mux_c: spi_mux  <= mux_next;
        // 4094 outputs kept as they are
        reg_soft_reset_c:
        begin
          led     <= '0;
          spi_mux <= '0;
          dac_ctl <= '0;
          adc_ctl <= '0;
        end
        // dac already set up before rails come on, leave it
        reg_powerup_c:
        begin
          led     <= '0;
          adc_ctl <= '0;
        end
        default:
        begin
        end
      endcase
    end
  end

endmodule

//--- logic/periph_router.sv
`timescale 1ns/10ps
// peripheral spi router
// gates chip selects from the mux register while cs2_n is low
// and picks the miso source for the host

module periph_router #(
  parameter int periph_count = 8
) (
  input  logic [periph_count-1:0] spi_mux,
  input  logic                    cs2_n,
  input  logic                    sdo,
  input  logic [periph_count-1:0] periph_miso,
  output logic [periph_count-1:0] periph_cs_n,
  output logic                    miso
);

  logic cs2_active;
  logic periph_sdo;

  assign cs2_active  = !cs2_n;

  // select low only for the chosen peripheral during cs2
  assign periph_cs_n = ~(spi_mux & {periph_count{cs2_active}});

  // wired or of selected peripheral outputs
  assign periph_sdo  = |(spi_mux & periph_miso);

  // register bank talks when cs2 is idle
  assign miso        = cs2_n ? sdo : periph_sdo;

endmodule

//--- logic/spi_reg_top.sv
`timescale 1ns/10ps
// spi register bank top level
// sampler, frame controller, register file and peripheral router

module spi_reg_top
  import spi_regs_pkg::*;
#(
  parameter int periph_count = 8
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    sclk,
  input  logic                    cs_n,
  input  logic                    mosi,
  input  logic                    cs2_n,
  input  logic [periph_count-1:0] periph_miso,
  output logic                    miso,
  output logic [periph_count-1:0] periph_cs_n,
  output ctl_nibble_t             led,
  output ctl_nibble_t             gpo_4094,
  output ctl_nibble_t             dac_ctl,
  output ctl_nibble_t             adc_ctl,
  output logic [periph_count-1:0] spi_mux
);

  // register bank serial out, before the miso mux
  logic sdo;

  spi_bit_if   bit_link ();
  reg_frame_if frame_link ();

  //////////////////////////////////////////////////////////////////////
  // host spi slave

  spi_sampler sampler0 (
    .clk    (clk),
    .arst_n (arst_n),
    .sclk   (sclk),
    .cs_n   (cs_n),
    .mosi   (mosi),
    .sdo    (sdo),
    .bits   (bit_link.sampler)
  );

  frame_control ctrl0 (
    .clk    (clk),
    .arst_n (arst_n),
    .bits   (bit_link.ctrl),
    .frame  (frame_link.ctrl)
  );

  reg_file #(
    .periph_count (periph_count)
  ) regs0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .frame    (frame_link.regs),
    .led      (led),
    .gpo_4094 (gpo_4094),
    .dac_ctl  (dac_ctl),
    .adc_ctl  (adc_ctl),
    .spi_mux  (spi_mux)
  );

  // peripheral select and miso
  periph_router #(
    .periph_count (periph_count)
  ) router0 (
    .spi_mux     (spi_mux),
    .cs2_n       (cs2_n),
    .sdo         (sdo),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

//--- tb/tb_spi_tasks.svh
// host side of the spi register bank testbench
// frame driver, random source, register model and result compares

`ifndef tb_spi_tasks_svh
`define tb_spi_tasks_svh

// model copy of the bank state
ctl_nibble_t ref_led;
ctl_nibble_t ref_gpo;
ctl_nibble_t ref_dac;
ctl_nibble_t ref_adc;
mux_t        ref_mux;

//////////////////////////////////////////////////////////////////////
// spi host

// n rising edges, then the drive delay
task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
  #drive_dly_c;
endtask

// mode 0 frame, address then data, miso taken on rising sclk
task automatic send_frame(input addr_t addr, input data_t data, input int nbits,
                          output data_t rd);
  logic [frame_bits_c:0] word;
  int i;
  // one spare zero bit for long frames
  word = {addr, data, 1'b0};
  rd   = '0;
  cs_n = 1'b0;
  for (i = 0; i < nbits; i++)
  begin
    mosi = word[frame_bits_c-i];
    wait_clks(sclk_half_c);
    sclk = 1'b1;
    // second byte carries the old value back
    if (i >= 8 && i < frame_bits_c)
      rd = {rd[6:0], miso};
    wait_clks(sclk_half_c);
    sclk = 1'b0;
  end
  wait_clks(sclk_half_c);
  cs_n = 1'b1;
  mosi = 1'b0;
  // commit settles inside the gap
  wait_clks(gap_clks_c);
endtask

//////////////////////////////////////////////////////////////////////
// random source and register model

function automatic logic [31:0] next_rand(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// valid register and command addresses only
function automatic addr_t random_addr(input logic [31:0] r);
  case (r[31:16] % 7)
    0: return reg_powerup_c;
    1: return reg_led_c;
    2: return reg_spi_mux_c;
    3: return reg_4094_c;
    4: return reg_dac_c;
    5: return reg_soft_reset_c;
    default: return reg_adc_c;
  endcase
endfunction

task automatic reset_model();
  ref_led = 4'h0;
  ref_gpo = 4'h0;
  // dac comes up all ones
  ref_dac = 4'hf;
  ref_adc = 4'h0;
  ref_mux = 8'h00;
endtask

function automatic data_t expected_read(input addr_t a);
  case (a)
    reg_led_c:     return {4'h0, ref_led};
    reg_spi_mux_c: return ref_mux;
    reg_4094_c:    return {4'h0, ref_gpo};
    reg_dac_c:     return {4'h0, ref_dac};
    reg_adc_c:     return {4'h0, ref_adc};
    default:       return 8'h00;
  endcase
endfunction

task automatic apply_commit(input addr_t a, input data_t d);
  case (a)
    reg_led_c:  ref_led = nibble_update(ref_led, d[3:0], d[7:4]);
    reg_4094_c: ref_gpo = nibble_update(ref_gpo, d[3:0], d[7:4]);
    reg_dac_c:  ref_dac = nibble_update(ref_dac, d[3:0], d[7:4]);
    reg_adc_c:  ref_adc = nibble_update(ref_adc, d[3:0], d[7:4]);
    reg_spi_mux_c:
    begin
      // index n selects peripheral n-1, out of range selects none
      ref_mux = '0;
      if (d[3:0] != 4'd0 && d[3:0] <= $bits(mux_t))
        ref_mux[d[3:0]-1] = 1'b1;
    end
    reg_soft_reset_c:
    begin
      ref_led = 4'h0;
      ref_mux = 8'h00;
      ref_dac = 4'h0;
      ref_adc = 4'h0;
    end
    reg_powerup_c:
    begin
      ref_led = 4'h0;
      ref_adc = 4'h0;
    end
    default:
    begin
    end
  endcase
endtask

// short frames only clock out the top bits of the old value
function automatic data_t visible_read(input data_t prev, input int nbits);
  int n;
  n = (nbits > frame_bits_c) ? frame_bits_c : nbits;
  return prev >> (frame_bits_c - n);
endfunction

//////////////////////////////////////////////////////////////////////
// compares

task automatic check_nibble(input string name, input ctl_nibble_t got, input ctl_nibble_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_mux(input string name, input mux_t got, input mux_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_byte(input string name, input data_t got, input data_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
  end
endtask

task automatic check_outputs(input ctl_nibble_t e_led, input ctl_nibble_t e_gpo,
                             input ctl_nibble_t e_dac, input ctl_nibble_t e_adc,
                             input mux_t e_mux);
  check_nibble("led", led, e_led);
  check_nibble("gpo_4094", gpo_4094, e_gpo);
  check_nibble("dac_ctl", dac_ctl, e_dac);
  check_nibble("adc_ctl", adc_ctl, e_adc);
  check_mux("spi_mux", spi_mux, e_mux);
endtask

// selects and miso with cs2_n low, then idle with cs2_n high
task automatic check_routing(input mux_t e_mux);
  int i;
  cs2_n       = 1'b0;
  periph_miso = e_mux;
  wait_clks(1);
  for (i = 0; i < periph_count_c; i++)
    check_bit($sformatf("periph_cs_n[%0d]", i), periph_cs_n[i], !e_mux[i]);
  check_bit("miso", miso, |e_mux);
  // unselected peripherals must not reach miso
  periph_miso = ~e_mux;
  wait_clks(1);
  check_bit("miso", miso, 1'b0);
  cs2_n       = 1'b1;
  periph_miso = '1;
  wait_clks(1);
  for (i = 0; i < periph_count_c; i++)
    check_bit($sformatf("periph_cs_n[%0d]", i), periph_cs_n[i], 1'b1);
  // idle bank output is low
  check_bit("miso", miso, 1'b0);
  periph_miso = '0;
endtask

`endif

//--- tb/tb_spi_reg_top.sv
`timescale 1ns/10ps
// testbench for the spi register bank
// directed frame table with expected values, then random frames
// checked against a register model

module tb_spi_reg_top
  import spi_regs_pkg::*;
();

  localparam int periph_count_c = 8;
  localparam int clk_half_c     = 20;
  localparam int drive_dly_c    = 2;
  localparam int sclk_half_c    = 4;
  localparam int gap_clks_c     = 10;
  localparam int rand_frames_c  = 200;
  // longest frame plus gap, routing checks and margin
  localparam int frame_clks_c   = 2 * sclk_half_c * (frame_bits_c + 1) + 60;

  // one directed frame, expected read is the old register value
  typedef struct packed {
    addr_t       addr;
    data_t       data;
    logic [4:0]  nbits;
    data_t       rd;
    ctl_nibble_t led;
    ctl_nibble_t gpo;
    ctl_nibble_t dac;
    ctl_nibble_t adc;
    mux_t        mux;
  } step_t;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic                      sclk;
  logic                      cs_n;
  logic                      mosi;
  logic                      cs2_n;
  logic [periph_count_c-1:0] periph_miso;
  logic                      miso;
  logic [periph_count_c-1:0] periph_cs_n;
  ctl_nibble_t               led;
  ctl_nibble_t               gpo_4094;
  ctl_nibble_t               dac_ctl;
  ctl_nibble_t               adc_ctl;
  logic [periph_count_c-1:0] spi_mux;

  int    errors = 0;
  int    checks = 0;
  step_t steps[$];

  `include "tb_spi_tasks.svh"

  spi_reg_top #(
    .periph_count (periph_count_c)
  ) dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .cs2_n       (cs2_n),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .led         (led),
    .gpo_4094    (gpo_4094),
    .dac_ctl     (dac_ctl),
    .adc_ctl     (adc_ctl),
    .spi_mux     (spi_mux)
  );

  always #clk_half_c clk = ~clk;

  task automatic add_step(input addr_t a, input data_t d, input int n, input data_t rd,
                          input ctl_nibble_t e_led, input ctl_nibble_t e_gpo,
                          input ctl_nibble_t e_dac, input ctl_nibble_t e_adc,
                          input mux_t e_mux);
    steps.push_back({a, d, n[4:0], rd, e_led, e_gpo, e_dac, e_adc, e_mux});
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed table
  // addr, data, bits, old value read, led, 4094, dac, adc, mux after

  task automatic build_table();
    // reset values read back, zero writes change nothing
    add_step(8'd7,  8'h00, 16, 8'h00, 4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd9,  8'h00, 16, 8'h00, 4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd10, 8'h00, 16, 8'h0f, 4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd14, 8'h00, 16, 8'h00, 4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd8,  8'h00, 16, 8'h00, 4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    // set, clear, toggle and mixed on each nibble
    add_step(8'd7,  8'h05, 16, 8'h00, 4'h5, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd7,  8'h0a, 16, 8'h05, 4'hf, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd7,  8'h30, 16, 8'h0f, 4'hc, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd7,  8'h66, 16, 8'h0c, 4'ha, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd7,  8'h81, 16, 8'h0a, 4'h3, 4'h0, 4'hf, 4'h0, 8'h00);
    add_step(8'd9,  8'h0c, 16, 8'h00, 4'h3, 4'hc, 4'hf, 4'h0, 8'h00);
    add_step(8'd9,  8'hff, 16, 8'h0c, 4'h3, 4'h3, 4'hf, 4'h0, 8'h00);
    add_step(8'd10, 8'h90, 16, 8'h0f, 4'h3, 4'h3, 4'h6, 4'h0, 8'h00);
    add_step(8'd10, 8'h33, 16, 8'h06, 4'h3, 4'h3, 4'h5, 4'h0, 8'h00);
    add_step(8'd14, 8'h07, 16, 8'h00, 4'h3, 4'h3, 4'h5, 4'h7, 8'h00);
    add_step(8'd14, 8'h52, 16, 8'h07, 4'h3, 4'h3, 4'h5, 4'h2, 8'h00);
    // mux index, one-hot, index 0 deselects
    add_step(8'd8,  8'h01, 16, 8'h00, 4'h3, 4'h3, 4'h5, 4'h2, 8'h01);
    add_step(8'd8,  8'h05, 16, 8'h01, 4'h3, 4'h3, 4'h5, 4'h2, 8'h10);
    add_step(8'd8,  8'h08, 16, 8'h10, 4'h3, 4'h3, 4'h5, 4'h2, 8'h80);
    add_step(8'd8,  8'h00, 16, 8'h80, 4'h3, 4'h3, 4'h5, 4'h2, 8'h00);
    add_step(8'd8,  8'h03, 16, 8'h00, 4'h3, 4'h3, 4'h5, 4'h2, 8'h04);
    // bad frame lengths, no write
    add_step(8'd7,  8'h0c, 15, 8'h03, 4'h3, 4'h3, 4'h5, 4'h2, 8'h04);
    add_step(8'd9,  8'hf0, 17, 8'h03, 4'h3, 4'h3, 4'h5, 4'h2, 8'h04);
    add_step(8'd8,  8'h02, 15, 8'h04, 4'h3, 4'h3, 4'h5, 4'h2, 8'h04);
    add_step(8'd10, 8'h0f, 17, 8'h05, 4'h3, 4'h3, 4'h5, 4'h2, 8'h04);
    // soft reset keeps 4094, powerup clears led and adc only
    add_step(8'd11, 8'h00, 16, 8'h00, 4'h0, 4'h3, 4'h0, 4'h0, 8'h00);
    add_step(8'd7,  8'h09, 16, 8'h00, 4'h9, 4'h3, 4'h0, 4'h0, 8'h00);
    add_step(8'd14, 8'h06, 16, 8'h00, 4'h9, 4'h3, 4'h0, 4'h6, 8'h00);
    add_step(8'd10, 8'h0a, 16, 8'h00, 4'h9, 4'h3, 4'ha, 4'h6, 8'h00);
    add_step(8'd8,  8'h02, 16, 8'h00, 4'h9, 4'h3, 4'ha, 4'h6, 8'h02);
    add_step(8'd6,  8'h00, 16, 8'h00, 4'h0, 4'h3, 4'ha, 4'h0, 8'h02);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    step_t       st;
    data_t       rd;
    data_t       exp_rd;
    addr_t       addr;
    data_t       data;
    logic [31:0] seed;
    int          k;
    arst_n      = 1'b0;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    cs2_n       = 1'b1;
    periph_miso = '0;
    build_table();
    reset_model();
    repeat (4) @(posedge clk);
    #drive_dly_c;
    arst_n = 1'b1;
    wait_clks(2);

    // values straight out of reset
    check_outputs(4'h0, 4'h0, 4'hf, 4'h0, 8'h00);
    check_routing(8'h00);

    for (k = 0; k < steps.size(); k++)
    begin
      st = steps[k];
      send_frame(st.addr, st.data, st.nbits, rd);
      // model follows so the random phase starts in step
      if (st.nbits == frame_bits_c)
        apply_commit(st.addr, st.data);
      check_byte("read data", rd, visible_read(st.rd, st.nbits));
      check_outputs(st.led, st.gpo, st.dac, st.adc, st.mux);
      check_routing(st.mux);
    end

    // random full frames against the model
    seed = 32'hc3fab439;
    for (k = 0; k < rand_frames_c; k++)
    begin
      seed   = next_rand(seed);
      addr   = random_addr(seed);
      seed   = next_rand(seed);
      data   = seed[23:16];
      exp_rd = expected_read(addr);
      send_frame(addr, data, frame_bits_c, rd);
      apply_commit(addr, data);
      check_byte("read data", rd, exp_rd);
      check_outputs(ref_led, ref_gpo, ref_dac, ref_adc, ref_mux);
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog, budget scales with the number of frames
  initial
  begin
    int budget;
    @(posedge arst_n);
    budget = (steps.size() + rand_frames_c) * frame_clks_c;
    repeat (budget) @(posedge clk);
    $display("timeout: run did not finish within %0d clk cycles, checks %0d, errors %0d",
             budget, checks, errors);
    $display("Test failed");
    $finish;
  end

endmodule

//--- all.f
+incdir+tb
logic/spi_regs_pkg.sv
logic/spi_bit_if.sv
logic/reg_frame_if.sv
logic/spi_sampler.sv
logic/frame_control.sv
logic/reg_file.sv
logic/periph_router.sv
logic/spi_reg_top.sv
tb/tb_spi_reg_top.sv
